// File: Makefile
VERILATOR ?= verilator
TOP       ?= l2_cache_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass message shows up in the output
sim: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
l2_pkg.sv
l2_req_queue.sv
l2_way.sv
l2_cache_datapath.sv
l2_cache_control.sv
l2_cache.sv
l2_cache_assert.sv
l2_cache_tb.sv

// File: l2_cache.sv
module l2_cache #(
    parameter int set_bits    = 4,
    parameter int queue_depth = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  l2_pkg::l2_req_t              req,
    output logic                         credit_return,
    output logic                         resp_valid,
    output l2_pkg::l2_resp_t             resp,
    output l2_pkg::l2_mem_req_t          mem_req,
    input  logic                         mem_resp,
    input  logic [l2_pkg::line_bits-1:0] mem_rdata
);
    import l2_pkg::*;

    l2_req_t              head;
    logic                 head_valid;
    logic                 pop;
    logic                 hit;
    logic                 victim_dirty;
    logic                 mem_read;
    logic                 mem_write;
    logic                 fill_sel;
    logic                 load_line;
    logic                 mark_dirty;
    logic                 load_lru;
    logic                 use_victim;
    logic                 addr_sel;
    logic [31:0]          mem_addr;
    logic [line_bits-1:0] mem_wdata;
    logic [line_bits-1:0] rdata;

    l2_req_queue #(
        .queue_depth(queue_depth)
    ) i_l2_req_queue (
        .clk,
        .reset,
        .req_valid,
        .req,
        .pop,
        .head_valid,
        .head,
        .credit_return
    );

    l2_cache_control i_l2_cache_control (
        .clk,
        .reset,
        .head_valid,
        .head_op (head.op),
        .hit,
        .victim_dirty,
        .mem_resp,
        .pop,
        .resp_valid,
        .mem_read,
        .mem_write,
        .fill_sel,
        .load_line,
        .mark_dirty,
        .load_lru,
        .use_victim,
        .addr_sel
    );

    l2_cache_datapath #(
        .set_bits(set_bits)
    ) i_l2_cache_datapath (
        .clk,
        .reset,
        .head,
        .mem_rdata,
        .fill_sel,
        .load_line,
        .mark_dirty,
        .load_lru,
        .use_victim,
        .addr_sel,
        .hit,
        .victim_dirty,
        .mem_addr,
        .mem_wdata,
        .rdata
    );

    assign resp.op    = head.op;
    assign resp.rdata = rdata;

    assign mem_req.read  = mem_read;
    assign mem_req.write = mem_write;
    assign mem_req.addr  = mem_addr;
    assign mem_req.wdata = mem_wdata;

endmodule

// File: l2_cache_assert.sv
module l2_cache_assert (
    input logic clk,
    input logic reset,
    input logic head_valid,
    input logic pop,
    input logic resp_valid,
    input logic mem_read,
    input logic mem_write
);

    // memory sees one direction at a time
    property p_mem_exclusive;
        @(posedge clk) disable iff (reset) !(mem_read && mem_write);
    endproperty

    property p_pop_has_head;
        @(posedge clk) disable iff (reset) pop |-> head_valid;
    endproperty

    // single-cycle response pulse
    property p_resp_pulse;
        @(posedge clk) disable iff (reset) resp_valid |=> !resp_valid;
    endproperty

    a_mem_exclusive: assert property (p_mem_exclusive)
        else $error("memory read and write asserted together");

    a_pop_has_head: assert property (p_pop_has_head)
        else $error("pop issued while the request queue is empty");

    a_resp_pulse: assert property (p_resp_pulse)
        else $error("resp_valid held for more than one cycle");

endmodule

bind l2_cache_control l2_cache_assert i_l2_cache_assert (
    .clk,
    .reset,
    .head_valid,
    .pop,
    .resp_valid,
    .mem_read,
    .mem_write
);

// File: l2_cache_control.sv
module l2_cache_control (
    input  logic           clk,
    input  logic           reset,
    input  logic           head_valid,
    input  l2_pkg::l2_op_e head_op,
    input  logic           hit,
    input  logic           victim_dirty,
    input  logic           mem_resp,
    output logic           pop,
    output logic           resp_valid,
    output logic           mem_read,
    output logic           mem_write,
    output logic           fill_sel,
    output logic           load_line,
    output logic           mark_dirty,
    output logic           load_lru,
    output logic           use_victim,
    output logic           addr_sel
);
    import l2_pkg::*;

    l2_state_e state;
    l2_state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (head_valid) begin
                    state_next = s_lookup;
                end
            end
            s_lookup: begin
                if (hit) begin
                    state_next = s_respond;
                end else if (victim_dirty) begin
                    state_next = s_writeback;
                end else begin
                    state_next = s_fill;
                end
            end
            // memory states hold until the handshake completes
            s_writeback: begin
                if (mem_resp) begin
                    state_next = s_fill;
                end
            end
            s_fill: begin
                if (mem_resp) begin
                    state_next = s_respond;
                end
            end
            s_respond: begin
                state_next = s_idle;
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    always_comb begin
        pop        = 1'b0;
        resp_valid = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        fill_sel   = 1'b0;
        load_line  = 1'b0;
        mark_dirty = 1'b0;
        load_lru   = 1'b0;
        use_victim = 1'b0;
        addr_sel   = 1'b0;
        case (state)
            s_writeback: begin
                // victim line out to its own address
                mem_write  = 1'b1;
                use_victim = 1'b1;
                addr_sel   = 1'b1;
            end
            s_fill: begin
                mem_read   = 1'b1;
                use_victim = 1'b1;
                fill_sel   = 1'b1;
                load_line  = mem_resp;
            end
            s_respond: begin
                // line now resident, so the hit way is the target
                resp_valid = 1'b1;
                pop        = 1'b1;
                load_lru   = 1'b1;
                load_line  = (head_op == op_write);
                mark_dirty = (head_op == op_write);
            end
            default: begin
                pop = 1'b0;
            end
        endcase
    end

endmodule

// File: l2_cache_datapath.sv
module l2_cache_datapath #(
    parameter int  set_bits = 4,
    localparam int tag_bits = 32 - l2_pkg::offset_bits - set_bits
) (
    input  logic                         clk,
    input  logic                         reset,
    input  l2_pkg::l2_req_t              head,
    input  logic [l2_pkg::line_bits-1:0] mem_rdata,
    input  logic                         fill_sel,
    input  logic                         load_line,
    input  logic                         mark_dirty,
    input  logic                         load_lru,
    input  logic                         use_victim,
    input  logic                         addr_sel,
    output logic                         hit,
    output logic                         victim_dirty,
    output logic [31:0]                  mem_addr,
    output logic [l2_pkg::line_bits-1:0] mem_wdata,
    output logic [l2_pkg::line_bits-1:0] rdata
);
    import l2_pkg::*;

    localparam int num_sets = 1 << set_bits;

    // address split
    logic [tag_bits-1:0]  tag;
    logic [set_bits-1:0]  index;

    logic [line_bits-1:0] line_in;

    // per-way signals
    logic [num_ways-1:0]  way_hit;
    logic [num_ways-1:0]  way_valid;
    logic [num_ways-1:0]  way_dirty;
    logic [num_ways-1:0]  way_load;
    logic [num_ways-1:0]  way_set_dirty;
    logic [num_ways-1:0]  way_clear_dirty;
    logic [tag_bits-1:0]  way_tag  [num_ways];
    logic [line_bits-1:0] way_line [num_ways];

    // lru bit names the way to evict next
    logic [num_sets-1:0]  lru_bits;
    logic                 lru_way;
    logic                 hit_way;
    logic                 sel_way;
    logic [tag_bits-1:0]  sel_tag;
    logic [line_bits-1:0] sel_line;

    assign tag   = head.addr[31 -: tag_bits];
    assign index = head.addr[offset_bits +: set_bits];

    // memory fill or upstream write data
    assign line_in = fill_sel ? mem_rdata : head.wdata;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        assign way_load[w]        = load_line && (sel_way == 1'(w));
        assign way_set_dirty[w]   = mark_dirty && (sel_way == 1'(w));
        assign way_clear_dirty[w] = way_load[w] && fill_sel;

        l2_way #(
            .set_bits(set_bits)
        ) i_way (
            .clk,
            .reset,
            .index,
            .tag,
            .load_line  (way_load[w]),
            .line_in,
            .set_dirty  (way_set_dirty[w]),
            .clear_dirty(way_clear_dirty[w]),
            .hit        (way_hit[w]),
            .valid      (way_valid[w]),
            .dirty      (way_dirty[w]),
            .tag_out    (way_tag[w]),
            .line_out   (way_line[w])
        );
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];
    assign lru_way = lru_bits[index];

    // hit way normally, lru victim during write-back and fill
    assign sel_way  = use_victim ? lru_way : hit_way;
    assign sel_tag  = way_tag[sel_way];
    assign sel_line = way_line[sel_way];

    assign victim_dirty = way_valid[lru_way] && way_dirty[lru_way];

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (load_lru) begin
            lru_bits[index] <= ~sel_way;
        end
    end

    // write-back address from victim tag, else line-aligned request
    assign mem_addr = addr_sel ? {sel_tag, index, {offset_bits{1'b0}}}
                               : {head.addr[31:offset_bits], {offset_bits{1'b0}}};

    assign mem_wdata = sel_line;

    // a write answers with the line it stores
    assign rdata = (head.op == op_write) ? head.wdata : sel_line;

endmodule

// File: l2_cache_tb.sv
module l2_cache_tb;
    import l2_pkg::*;

    localparam int set_bits       = 4;
    localparam int queue_depth    = 4;
    localparam int clk_period     = 20;
    localparam int reset_cycles   = 10;
    localparam int tag_bits       = 32 - offset_bits - set_bits;
    localparam int num_sets       = 1 << set_bits;
    // memory model covers addresses below 8 KiB
    localparam int mem_index_bits = 8;
    localparam int mem_lines      = 1 << mem_index_bits;

    logic                 clk;
    logic                 reset;
    logic                 req_valid;
    l2_req_t              req;
    logic                 credit_return;
    logic                 resp_valid;
    l2_resp_t             resp;
    l2_mem_req_t          mem_req;
    logic                 mem_resp;
    logic [line_bits-1:0] mem_rdata;

    // stimulus table with one row per request
    string                t_name    [$];
    l2_req_t              t_req     [$];
    l2_resp_t             t_exp     [$];
    bit                   t_wb_chk  [$];
    logic [31:0]          t_wb_addr [$];

    logic [line_bits-1:0] mem_model  [mem_lines];
    logic [line_bits-1:0] golden     [mem_lines];
    // line contents as of the last retired request
    logic [line_bits-1:0] done_model [mem_lines];

    // reference cache state as of the last retired request
    logic [tag_bits-1:0]  model_tag   [num_sets][num_ways];
    bit                   model_valid [num_sets][num_ways];
    bit                   model_dirty [num_sets][num_ways];
    // way to evict next in each set
    bit                   model_lru   [num_sets];

    int          pending [$];
    int          next_test;
    int          credits;
    int          credit_pulses;
    int          num_done;
    int          wb_checked_for;
    bit          table_ready;
    bit          mem_busy;
    int          mem_wait;
    l2_mem_req_t mem_held;

    l2_cache #(
        .set_bits   (set_bits),
        .queue_depth(queue_depth)
    ) i_l2_cache (
        .clk,
        .reset,
        .req_valid,
        .req,
        .credit_return,
        .resp_valid,
        .resp,
        .mem_req,
        .mem_resp,
        .mem_rdata
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic int line_index(input logic [31:0] addr);
        return int'(addr[offset_bits +: mem_index_bits]);
    endfunction

    function automatic int set_of(input logic [31:0] addr);
        return int'(addr[offset_bits +: set_bits]);
    endfunction

    // aligned address repeated over the whole line
    function automatic logic [line_bits-1:0] init_pattern(input logic [31:0] addr);
        return {8{addr[31:offset_bits], {offset_bits{1'b0}}}};
    endfunction

    function automatic logic [line_bits-1:0] random_line();
        logic [line_bits-1:0] value;
        for (int w = 0; w < line_bits / 32; w++) begin
            value[w*32 +: 32] = $urandom;
        end
        return value;
    endfunction

    // way holding the line in the reference cache, or -1
    function automatic int resident_way(input logic [31:0] addr);
        int s;
        int way;
        s   = set_of(addr);
        way = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == addr[31 -: tag_bits]) begin
                way = w;
            end
        end
        return way;
    endfunction

    // lru replacement with write-allocate
    task automatic update_cache_model(input l2_req_t r);
        int s;
        int way;
        s   = set_of(r.addr);
        way = resident_way(r.addr);
        if (way < 0) begin
            way                 = int'(model_lru[s]);
            model_valid[s][way] = 1'b1;
            model_dirty[s][way] = 1'b0;
            model_tag[s][way]   = r.addr[31 -: tag_bits];
        end
        if (r.op == op_write) begin
            model_dirty[s][way] = 1'b1;
        end
        model_lru[s] = (way == 0);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_resp(input string name, input l2_resp_t exp, input l2_resp_t act);
        if (act !== exp) begin
            report_failure({$sformatf("[FAIL] %s expected op=%0d rdata=%h", name,
                                      exp.op, exp.rdata),
                            $sformatf(" actual op=%0d rdata=%h", act.op, act.rdata)});
        end
    endtask

    task automatic check_mem_req(input string name, input l2_mem_req_t exp,
                                 input l2_mem_req_t act);
        l2_mem_req_t cmp;
        cmp = act;
        // payload of a fill is meaningless
        if (exp.read) begin
            cmp.wdata = exp.wdata;
        end
        if (cmp !== exp) begin
            report_failure({$sformatf("[FAIL] %s expected r=%b w=%b addr=%h wdata=%h", name,
                                      exp.read, exp.write, exp.addr, exp.wdata),
                            $sformatf(" actual r=%b w=%b addr=%h wdata=%h", act.read,
                                      act.write, act.addr, act.wdata)});
        end
    endtask

    // expected data follows the golden array at the moment of the request
    task automatic add_test(input string name, input l2_op_e op, input logic [31:0] addr,
                            input logic [line_bits-1:0] wdata, input bit wb_chk,
                            input logic [31:0] wb_addr);
        l2_req_t  r;
        l2_resp_t e;
        r.op    = op;
        r.addr  = addr;
        r.wdata = wdata;
        e.op    = op;
        if (op == op_write) begin
            golden[line_index(addr)] = wdata;
            e.rdata = wdata;
        end else begin
            e.rdata = golden[line_index(addr)];
        end
        t_name.push_back(name);
        t_req.push_back(r);
        t_exp.push_back(e);
        t_wb_chk.push_back(wb_chk);
        t_wb_addr.push_back(wb_addr);
    endtask

    task automatic build_table();
        logic [31:0] addr;
        add_test("read_miss_clean", op_read, 32'h0000_0020, '0, 1'b0, 32'h0);
        add_test("write_line", op_write, 32'h0000_0040, random_line(), 1'b0, 32'h0);
        add_test("read_after_write", op_read, 32'h0000_0040, '0, 1'b0, 32'h0);
        // three tags in set 3 evict tag 0 first and tag 1 after it
        add_test("evict_write_a", op_write, 32'h0000_0060, random_line(), 1'b0, 32'h0);
        add_test("evict_write_b", op_write, 32'h0000_0260, random_line(), 1'b0, 32'h0);
        add_test("evict_write_c", op_write, 32'h0000_0460, random_line(), 1'b1, 32'h0000_0060);
        add_test("evict_read_a", op_read, 32'h0000_0060, '0, 1'b1, 32'h0000_0260);
        // back-to-back burst into set 4
        for (int i = 0; i < 2 * queue_depth; i++) begin
            addr = (32'(i / 2) << 9) | 32'h0000_0080;
            if (i % 2 == 0) begin
                add_test($sformatf("burst_write_%0d", i), op_write, addr, random_line(),
                         1'b0, 32'h0);
            end else begin
                add_test($sformatf("burst_read_%0d", i), op_read, addr, '0, 1'b0, 32'h0);
            end
        end
        // random traffic over sets 6 and 7 with four tags each
        for (int i = 0; i < 40; i++) begin
            addr = ($urandom_range(3, 0) << 9) | ($urandom_range(7, 6) << offset_bits);
            if ($urandom_range(1, 0) == 1) begin
                add_test($sformatf("random_write_%0d", i), op_write, addr, random_line(),
                         1'b0, 32'h0);
            end else begin
                add_test($sformatf("random_read_%0d", i), op_read, addr, '0, 1'b0, 32'h0);
            end
        end
    endtask

    task automatic memory_cycle();
        l2_mem_req_t exp;
        int          k;
        int          s;
        int          victim;
        bit          wb_due;
        mem_resp = 1'b0;
        if (mem_busy) begin
            check_mem_req("mem_hold", mem_held, mem_req);
            mem_wait--;
            if (mem_wait == 0) begin
                if (mem_held.write) begin
                    mem_model[line_index(mem_held.addr)] = mem_held.wdata;
                end else begin
                    mem_rdata = mem_model[line_index(mem_held.addr)];
                end
                mem_resp = 1'b1;
                mem_busy = 1'b0;
            end
        end else if (mem_req.read || mem_req.write) begin
            if (pending.size() == 0) begin
                report_failure("memory request seen with no request outstanding");
            end else if (mem_req.addr[31:offset_bits+mem_index_bits] != '0) begin
                report_failure("memory request outside the modeled address range");
            end else if (resident_way(t_req[pending[0]].addr) >= 0) begin
                report_failure("memory request issued for a line already in the cache");
            end else begin
                k      = pending[0];
                s      = set_of(t_req[k].addr);
                victim = int'(model_lru[s]);
                // a dirty victim goes out once before the fill
                wb_due = (wb_checked_for != k) &&
                         (t_wb_chk[k] || (model_valid[s][victim] && model_dirty[s][victim]));
                exp.wdata = '0;
                if (wb_due) begin
                    exp.read  = 1'b0;
                    exp.write = 1'b1;
                    if (t_wb_chk[k]) begin
                        exp.addr = t_wb_addr[k];
                    end else begin
                        exp.addr = {model_tag[s][victim],
                                    t_req[k].addr[offset_bits +: set_bits],
                                    {offset_bits{1'b0}}};
                    end
                    exp.wdata      = done_model[line_index(exp.addr)];
                    wb_checked_for = k;
                end else begin
                    exp.read  = 1'b1;
                    exp.write = 1'b0;
                    exp.addr  = {t_req[k].addr[31:offset_bits], {offset_bits{1'b0}}};
                end
                check_mem_req(t_name[k], exp, mem_req);
                mem_held = mem_req;
                mem_busy = 1'b1;
                mem_wait = $urandom_range(6, 1);
            end
        end
    endtask

    task automatic service_cycle();
        int k;
        if (credit_return !== resp_valid) begin
            report_failure("credit_return did not pulse together with resp_valid");
        end else if (resp_valid) begin
            if (pending.size() == 0) begin
                report_failure("response arrived with no request outstanding");
            end else begin
                k = pending.pop_front();
                check_resp(t_name[k], t_exp[k], resp);
                if (t_req[k].op == op_write) begin
                    done_model[line_index(t_req[k].addr)] = t_req[k].wdata;
                end
                update_cache_model(t_req[k]);
                num_done++;
            end
        end
        memory_cycle();
        req_valid = 1'b0;
        if (next_test < t_req.size() && credits > 0) begin
            req_valid = 1'b1;
            req       = t_req[next_test];
            pending.push_back(next_test);
            credits--;
            next_test++;
        end
        // a returned credit is spent from the next cycle on
        if (credit_return) begin
            if (credits == queue_depth) begin
                report_failure("credit returned while no credit was outstanding");
            end else begin
                credits++;
                credit_pulses++;
            end
        end
    endtask

    initial begin
        reset          = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        mem_resp       = 1'b0;
        mem_rdata      = '0;
        credits        = queue_depth;
        credit_pulses  = 0;
        num_done       = 0;
        next_test      = 0;
        wb_checked_for = -1;
        mem_busy       = 1'b0;
        mem_wait       = 0;
        mem_held       = '0;
        table_ready    = 1'b0;
        void'($urandom(32'h4bab));
        for (int i = 0; i < mem_lines; i++) begin
            mem_model[i]  = init_pattern(32'(i) << offset_bits);
            golden[i]     = init_pattern(32'(i) << offset_bits);
            done_model[i] = init_pattern(32'(i) << offset_bits);
        end
        for (int s = 0; s < num_sets; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < num_ways; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
            end
        end
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) begin
            @(negedge clk);
            if ({resp_valid, credit_return, mem_req.read, mem_req.write} !== 4'b0000) begin
                report_failure($sformatf("[FAIL] reset_idle expected 0000 actual %b",
                    {resp_valid, credit_return, mem_req.read, mem_req.write}));
            end
        end
        reset = 1'b0;
        while (num_done < t_req.size()) begin
            @(negedge clk);
            service_cycle();
        end
        if (credit_pulses != t_req.size() || credits != queue_depth) begin
            report_failure({$sformatf("[FAIL] credit_balance expected pulses=%0d credits=%0d",
                                      t_req.size(), queue_depth),
                            $sformatf(" actual pulses=%0d credits=%0d", credit_pulses,
                                      credits)});
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    // watchdog with a generous bound per request
    initial begin
        wait (table_ready);
        #((reset_cycles + t_req.size() * 40) * clk_period);
        report_failure("simulation timed out waiting for responses");
    end

endmodule

// File: l2_pkg.sv
package l2_pkg;

    // line geometry
    localparam int line_bits   = 256;
    localparam int offset_bits = 5;

    // a single lru bit per set can only name one of two ways
    localparam int num_ways = 2;

    // whole-line access only
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } l2_op_e;

    typedef enum logic [2:0] {
        s_idle      = 3'd0,
        s_lookup    = 3'd1,
        s_writeback = 3'd2,
        s_fill      = 3'd3,
        s_respond   = 3'd4
    } l2_state_e;

    // upstream request, one queue entry
    typedef struct packed {
        l2_op_e               op;
        logic [31:0]          addr;
        logic [line_bits-1:0] wdata;
    } l2_req_t;

    // upstream response
    typedef struct packed {
        l2_op_e               op;
        logic [line_bits-1:0] rdata;
    } l2_resp_t;

    // physical memory request, read and write are exclusive
    typedef struct packed {
        logic                 read;
        logic                 write;
        logic [31:0]          addr;
        logic [line_bits-1:0] wdata;
    } l2_mem_req_t;

endpackage

// File: l2_req_queue.sv
module l2_req_queue #(
    parameter int queue_depth = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            req_valid,
    input  l2_pkg::l2_req_t req,
    input  logic            pop,
    output logic            head_valid,
    output l2_pkg::l2_req_t head,
    output logic            credit_return
);
    import l2_pkg::*;

    localparam int ptr_bits   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_bits = $clog2(queue_depth + 1);

    l2_req_t               entries [queue_depth];
    logic [ptr_bits-1:0]   wr_ptr;
    logic [ptr_bits-1:0]   rd_ptr;
    logic [count_bits-1:0] count;
    logic                  full;
    logic                  push;
    logic                  do_pop;

    // wrap at queue_depth, which need not be a power of two
    function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
        logic [ptr_bits-1:0] nxt;
        nxt = (ptr == ptr_bits'(queue_depth - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign full   = (count == count_bits'(queue_depth));
    assign push   = req_valid && !full;
    assign do_pop = pop && head_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= req;
        end
    end

    assign head_valid = (count != '0);
    assign head       = entries[rd_ptr];

    // one credit back per retired request
    assign credit_return = do_pop;

endmodule

// File: l2_way.sv
module l2_way #(
    parameter int  set_bits = 4,
    localparam int tag_bits = 32 - l2_pkg::offset_bits - set_bits
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [set_bits-1:0]          index,
    input  logic [tag_bits-1:0]          tag,
    input  logic                         load_line,
    input  logic [l2_pkg::line_bits-1:0] line_in,
    input  logic                         set_dirty,
    input  logic                         clear_dirty,
    output logic                         hit,
    output logic                         valid,
    output logic                         dirty,
    output logic [tag_bits-1:0]          tag_out,
    output logic [l2_pkg::line_bits-1:0] line_out
);
    import l2_pkg::*;

    localparam int num_sets = 1 << set_bits;

    logic [tag_bits-1:0]  tag_mem  [num_sets];
    logic [line_bits-1:0] data_mem [num_sets];
    logic [num_sets-1:0]  valid_bits;
    logic [num_sets-1:0]  dirty_bits;

    // tag and line are written together on fill or store
    always_ff @(posedge clk) begin
        if (load_line) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= line_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (load_line) begin
                valid_bits[index] <= 1'b1;
            end
            // a store in the same cycle wins over a clean fill
            if (set_dirty) begin
                dirty_bits[index] <= 1'b1;
            end else if (clear_dirty) begin
                dirty_bits[index] <= 1'b0;
            end
        end
    end

    // combinational read of the addressed set
    assign valid    = valid_bits[index];
    assign dirty    = dirty_bits[index];
    assign tag_out  = tag_mem[index];
    assign line_out = data_mem[index];

    assign hit = valid && (tag_out == tag);

endmodule
